// File: wl_config.svh
/* Weight loader configuration */

`ifndef WL_CONFIG_SVH
`define WL_CONFIG_SVH

// ============================================================
// Word and address widths
// ============================================================
`define WL_DATA_W 8
`define WL_ADDR_W 8

// ============================================================
// Layer dimensions
// ============================================================
// Layer-1 input and output features
`define WL_FEAT_IN 20
`define WL_FEAT_OUT 4
// Layer-2 output features
`define WL_FEAT_FINAL 3

// Four sections: W1, A1, W2, A2
`define WL_TOTAL_WORDS ( \
  (`WL_FEAT_IN * `WL_FEAT_OUT) + \
  (2 * `WL_FEAT_OUT) + \
  (`WL_FEAT_OUT * `WL_FEAT_FINAL) + \
  (2 * `WL_FEAT_FINAL))

`endif

// File: wl_pkg.sv
/* Weight loader types */

`include "wl_config.svh"

package wl_pkg;

  // ============================================================
  // Basic types
  // ============================================================
  typedef logic [`WL_DATA_W-1:0] word_t;
  typedef logic [`WL_ADDR_W-1:0] waddr_t;

  // Row or column index, sized for the longest dimension
  localparam int IDX_W = $clog2(`WL_FEAT_IN + 1);
  typedef logic [IDX_W-1:0] idx_t;

  // ============================================================
  // Weight memory sections, in stream order
  // ============================================================
  typedef enum logic [2:0] {
    SEC_W1,
    SEC_A1,
    SEC_W2,
    SEC_A2,
    SEC_DONE
  } section_e;

  // ============================================================
  // One placed word
  // ============================================================
  // Attention sections leave row at zero and use col as the index
  typedef struct packed {
    logic     vld;
    section_e sec;
    idx_t     row;
    idx_t     col;
    word_t    data;
  } wl_wr_t;

endpackage

// File: weight_stream_seq.sv
/* Weight stream sequencer */

`include "wl_config.svh"

module weight_stream_seq (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             load_i,
  output wl_pkg::waddr_t   wmem_addr_o,
  input  wl_pkg::word_t    wmem_data_i,
  output wl_pkg::wl_wr_t   wr_o,
  output wl_pkg::section_e sec_o
);

  // One past the last weight address
  localparam wl_pkg::waddr_t END_ADDR = wl_pkg::waddr_t'(`WL_TOTAL_WORDS);

  wl_pkg::waddr_t   addr_q;
  wl_pkg::idx_t     row_q;
  wl_pkg::idx_t     col_q;
  wl_pkg::section_e sec_q;

  wl_pkg::idx_t     col_max;
  wl_pkg::idx_t     row_max;
  wl_pkg::section_e sec_step;
  logic             issue;
  logic             col_last;
  logic             row_last;

  // Tag of the address issued last cycle
  logic             tag_vld_q;
  wl_pkg::section_e tag_sec_q;
  wl_pkg::idx_t     tag_row_q;
  wl_pkg::idx_t     tag_col_q;

  // ============================================================
  // Section bounds
  // ============================================================
  always_comb begin
    col_max  = '0;
    row_max  = '0;
    sec_step = wl_pkg::SEC_DONE;
    case (sec_q)
      wl_pkg::SEC_W1: begin
        col_max  = wl_pkg::idx_t'(`WL_FEAT_OUT - 1);
        row_max  = wl_pkg::idx_t'(`WL_FEAT_IN - 1);
        sec_step = wl_pkg::SEC_A1;
      end
      wl_pkg::SEC_A1: begin
        col_max  = wl_pkg::idx_t'(2 * `WL_FEAT_OUT - 1);
        sec_step = wl_pkg::SEC_W2;
      end
      wl_pkg::SEC_W2: begin
        col_max  = wl_pkg::idx_t'(`WL_FEAT_FINAL - 1);
        row_max  = wl_pkg::idx_t'(`WL_FEAT_OUT - 1);
        sec_step = wl_pkg::SEC_A2;
      end
      wl_pkg::SEC_A2: begin
        col_max  = wl_pkg::idx_t'(2 * `WL_FEAT_FINAL - 1);
        // Held here until the final word lands
        sec_step = wl_pkg::SEC_A2;
      end
      default: begin
        sec_step = wl_pkg::SEC_DONE;
      end
    endcase
  end

  assign issue    = load_i && (sec_q != wl_pkg::SEC_DONE) && (addr_q != END_ADDR);
  assign col_last = (col_q == col_max);
  assign row_last = (row_q == row_max);

  // ============================================================
  // Address, index and section FSM
  // ============================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      addr_q <= '0;
      row_q  <= '0;
      col_q  <= '0;
      sec_q  <= wl_pkg::SEC_W1;
    end else if (issue) begin
      addr_q <= addr_q + 1'b1;
      if (col_last) begin
        col_q <= '0;
        if (row_last) begin
          row_q <= '0;
          sec_q <= sec_step;
        end else begin
          row_q <= row_q + 1'b1;
        end
      end else begin
        col_q <= col_q + 1'b1;
      end
    end else if (sec_q == wl_pkg::SEC_A2 && addr_q == END_ADDR && tag_vld_q) begin
      // Last word is on wr this cycle
      sec_q <= wl_pkg::SEC_DONE;
    end
  end

  // ============================================================
  // Tag pipeline, aligned with the memory latency
  // ============================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tag_vld_q <= 1'b0;
    end else begin
      tag_vld_q <= issue;
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      tag_sec_q <= sec_q;
      tag_row_q <= row_q;
      tag_col_q <= col_q;
    end
  end

  always_comb begin
    wr_o.vld  = tag_vld_q;
    wr_o.sec  = tag_sec_q;
    wr_o.row  = tag_row_q;
    wr_o.col  = tag_col_q;
    wr_o.data = wmem_data_i;
  end

  assign wmem_addr_o = addr_q;
  assign sec_o       = sec_q;

  // End of memory is reached only in the last section
  a_addr_bound: assert property (@(posedge clk) disable iff (!rst_n)
    (addr_q == END_ADDR) |->
      (sec_q == wl_pkg::SEC_A2 || sec_q == wl_pkg::SEC_DONE));

endmodule

// File: weight_bank_array.sv
/* Layer-1 weight banks */

`include "wl_config.svh"

module weight_bank_array (
  input  logic                              clk,
  input  logic                              rst_n,
  input  wl_pkg::wl_wr_t                    wr_i,
  input  wl_pkg::idx_t  [`WL_FEAT_OUT-1:0] rd_addr_i,
  output wl_pkg::word_t [`WL_FEAT_OUT-1:0] rd_data_o
);

  logic w1_wr;

  assign w1_wr = wr_i.vld && (wr_i.sec == wl_pkg::SEC_W1);

  // ============================================================
  // One bank per output column
  // ============================================================
  for (genvar b = 0; b < `WL_FEAT_OUT; b++) begin : g_bank
    wl_pkg::word_t mem [`WL_FEAT_IN];
    wl_pkg::word_t rd_q;
    logic          we;

    // Column picks the bank, row is the bank address
    assign we = w1_wr && (wr_i.col == wl_pkg::idx_t'(b));

    always_ff @(posedge clk) begin
      if (we) begin
        mem[wr_i.row] <= wr_i.data;
      end
    end

    // Registered read port
    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        rd_q <= '0;
      end else begin
        rd_q <= mem[rd_addr_i[b]];
      end
    end

    assign rd_data_o[b] = rd_q;
  end

  // ============================================================
  // Checks
  // ============================================================
  // Sequencer tags must land inside the bank array
  a_w1_col: assert property (@(posedge clk) disable iff (!rst_n)
    w1_wr |-> (wr_i.col < wl_pkg::idx_t'(`WL_FEAT_OUT)));

  a_w1_row: assert property (@(posedge clk) disable iff (!rst_n)
    w1_wr |-> (wr_i.row < wl_pkg::idx_t'(`WL_FEAT_IN)));

endmodule

// File: attn_vector_reg.sv
/* Attention vector register */

`include "wl_config.svh"

module attn_vector_reg #(
  parameter int               LEN = 2 * `WL_FEAT_OUT,
  parameter wl_pkg::section_e SEC = wl_pkg::SEC_A1
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  wl_pkg::wl_wr_t           wr_i,
  output wl_pkg::word_t [LEN-1:0] vec_o
);

  wl_pkg::word_t [LEN-1:0] vec_q;
  logic                    accept;

  // Only words of this instance's section
  assign accept = wr_i.vld && (wr_i.sec == SEC);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vec_q <= '0;
    end else if (accept) begin
      for (int i = 0; i < LEN; i++) begin
        if (wr_i.col == wl_pkg::idx_t'(i)) begin
          vec_q[i] <= wr_i.data;
        end
      end
    end
  end

  assign vec_o = vec_q;

  // Sequencer bound for this section must match LEN
  a_idx_range: assert property (@(posedge clk) disable iff (!rst_n)
    accept |-> (wr_i.col < wl_pkg::idx_t'(LEN)));

endmodule

// File: conv2_weight_reg.sv
/* Layer-2 weight register */

`include "wl_config.svh"

module conv2_weight_reg (
  input  logic                                                clk,
  input  logic                                                rst_n,
  input  wl_pkg::wl_wr_t                                      wr_i,
  output wl_pkg::word_t [`WL_FEAT_FINAL-1:0][`WL_FEAT_OUT-1:0] w_o
);

  wl_pkg::word_t [`WL_FEAT_FINAL-1:0][`WL_FEAT_OUT-1:0] w_q;
  logic                                                 accept;

  assign accept = wr_i.vld && (wr_i.sec == wl_pkg::SEC_W2);

  // ============================================================
  // Transposed store
  // ============================================================
  // Stream is row major over FEAT_OUT x FEAT_FINAL, kept as [col][row]
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      w_q <= '0;
    end else if (accept) begin
      for (int c = 0; c < `WL_FEAT_FINAL; c++) begin
        for (int r = 0; r < `WL_FEAT_OUT; r++) begin
          if (wr_i.col == wl_pkg::idx_t'(c) && wr_i.row == wl_pkg::idx_t'(r)) begin
            w_q[c][r] <= wr_i.data;
          end
        end
      end
    end
  end

  assign w_o = w_q;

endmodule

// File: weight_loader_top.sv
/* Weight loader top level */

`include "wl_config.svh"

module weight_loader_top (
  input  logic                                                clk,
  input  logic                                                rst_n,
  input  logic                                                load_i,

  // External weight memory
  output wl_pkg::waddr_t                                      wmem_addr_o,
  input  wl_pkg::word_t                                       wmem_data_i,

  output logic                                                ready_o,

  // Layer-1 bank read ports
  input  wl_pkg::idx_t  [`WL_FEAT_OUT-1:0]                    bank_rd_addr_i,
  output wl_pkg::word_t [`WL_FEAT_OUT-1:0]                    bank_rd_data_o,

  // Captured registers
  output wl_pkg::word_t [2*`WL_FEAT_OUT-1:0]                  attn1_o,
  output wl_pkg::word_t [`WL_FEAT_FINAL-1:0][`WL_FEAT_OUT-1:0] w2_o,
  output wl_pkg::word_t [2*`WL_FEAT_FINAL-1:0]                attn2_o
);

  wl_pkg::wl_wr_t   wr;
  wl_pkg::section_e sec;
  logic             ready_q;

  // ============================================================
  // Sequencer
  // ============================================================
  weight_stream_seq u_seq (
    .clk         (clk),
    .rst_n       (rst_n),
    .load_i      (load_i),
    .wmem_addr_o (wmem_addr_o),
    .wmem_data_i (wmem_data_i),
    .wr_o        (wr),
    .sec_o       (sec)
  );

  // ============================================================
  // Destinations
  // ============================================================
  weight_bank_array u_w1_banks (
    .clk       (clk),
    .rst_n     (rst_n),
    .wr_i      (wr),
    .rd_addr_i (bank_rd_addr_i),
    .rd_data_o (bank_rd_data_o)
  );

  attn_vector_reg #(
    .LEN (2 * `WL_FEAT_OUT),
    .SEC (wl_pkg::SEC_A1)
  ) u_attn1 (
    .clk   (clk),
    .rst_n (rst_n),
    .wr_i  (wr),
    .vec_o (attn1_o)
  );

  conv2_weight_reg u_w2 (
    .clk   (clk),
    .rst_n (rst_n),
    .wr_i  (wr),
    .w_o   (w2_o)
  );

  attn_vector_reg #(
    .LEN (2 * `WL_FEAT_FINAL),
    .SEC (wl_pkg::SEC_A2)
  ) u_attn2 (
    .clk   (clk),
    .rst_n (rst_n),
    .wr_i  (wr),
    .vec_o (attn2_o)
  );

  // ============================================================
  // Ready level
  // ============================================================
  // Sticky until reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ready_q <= 1'b0;
    end else if (sec == wl_pkg::SEC_DONE) begin
      ready_q <= 1'b1;
    end
  end

  assign ready_o = ready_q;

endmodule

// File: tb_weight_rom.sv
/* External weight memory model */

`include "wl_config.svh"

module tb_weight_rom (
  input  logic                  clk,
  input  logic [`WL_ADDR_W-1:0] addr_i,
  output logic [`WL_DATA_W-1:0] data_o
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam int DEPTH = 2 ** `WL_ADDR_W;

  logic [`WL_DATA_W-1:0] mem [DEPTH];

  // Every location gets word(a) = low bits of a * 37 + 11
  initial begin
    logic [31:0] v;
    for (int a = 0; a < DEPTH; a++) begin
      v = a * 37 + 11;
      mem[a] = v[`WL_DATA_W-1:0];
    end
    data_o = '0;
  end

  // ============================================================
  // One-cycle read latency
  // ============================================================
  always @(posedge clk) begin
    data_o <= mem[addr_i];
  end

endmodule

// File: tb_weight_loader.sv
/* Weight loader testbench */

`include "wl_config.svh"

module tb_weight_loader;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int DW    = `WL_DATA_W;
  localparam int AW    = `WL_ADDR_W;
  localparam int FI    = `WL_FEAT_IN;
  localparam int FO    = `WL_FEAT_OUT;
  localparam int FF    = `WL_FEAT_FINAL;
  localparam int TOTAL = `WL_TOTAL_WORDS;
  localparam int IDX_W = $clog2(`WL_FEAT_IN + 1);
  localparam logic [31:0] SEED = 32'h8851_c769;

  // Section codes for the reference model
  localparam int S_W1 = 0;
  localparam int S_A1 = 1;
  localparam int S_W2 = 2;
  localparam int S_A2 = 3;

  logic clk;
  logic rst_n;
  logic load;
  logic ready;
  logic [AW-1:0] wmem_addr;
  logic [DW-1:0] wmem_data;
  logic [FO-1:0][IDX_W-1:0] bank_rd_addr;
  logic [FO-1:0][DW-1:0] bank_rd_data;
  logic [2*FO-1:0][DW-1:0] attn1;
  logic [FF-1:0][FO-1:0][DW-1:0] w2;
  logic [2*FF-1:0][DW-1:0] attn2;
  logic [31:0] rnd_state;

  // Address stream monitor state
  int   prev_addr;
  int   exp_addr;
  int   end_cnt;
  int   wr_cnt;
  logic prev_load;
  logic prev_vld;

  weight_loader_top DUT (
    .clk            (clk),
    .rst_n          (rst_n),
    .load_i         (load),
    .wmem_addr_o    (wmem_addr),
    .wmem_data_i    (wmem_data),
    .ready_o        (ready),
    .bank_rd_addr_i (bank_rd_addr),
    .bank_rd_data_o (bank_rd_data),
    .attn1_o        (attn1),
    .w2_o           (w2),
    .attn2_o        (attn2)
  );

  tb_weight_rom u_rom (
    .clk    (clk),
    .addr_i (wmem_addr),
    .data_o (wmem_data)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ============================================================
  // Reference model and helpers
  // ============================================================
  function automatic logic [DW-1:0] ref_word(input int sec, input int idx);
    int          base;
    logic [31:0] v;
    case (sec)
      S_W1:    base = 0;
      S_A1:    base = FI * FO;
      S_W2:    base = FI * FO + 2 * FO;
      default: base = FI * FO + 2 * FO + FO * FF;
    endcase
    v = (base + idx) * 37 + 11;
    return v[DW-1:0];
  endfunction

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %s got 0x%0h expected 0x%0h", name, got, exp);
      $display("** FAIL **");
      $fatal(1, "Value mismatch");
    end
  endtask

  task automatic fail_timeout(input string what);
    $display("Timed out waiting for %s", what);
    $display("** FAIL **");
    $fatal(1, "Timeout");
  endtask

  task automatic apply_reset();
    rst_n = 1'b0;
    load  = 1'b0;
    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;
  endtask

  task automatic check_cleared();
    check_value("ready_o", 32'(ready), 32'h0);
    for (int i = 0; i < 2 * FO; i++) begin
      check_value($sformatf("attn1_o[%0d]", i), 32'(attn1[i]), 32'h0);
    end
    for (int c = 0; c < FF; c++) begin
      for (int r = 0; r < FO; r++) begin
        check_value($sformatf("w2_o[%0d][%0d]", c, r), 32'(w2[c][r]), 32'h0);
      end
    end
    for (int i = 0; i < 2 * FF; i++) begin
      check_value($sformatf("attn2_o[%0d]", i), 32'(attn2[i]), 32'h0);
    end
  endtask

  // Holds load high, or drops it on random cycles, until ready
  task automatic run_load(input bit random_drops, input int max_cycles);
    int n;
    n = 0;
    while (!ready) begin
      if (n == max_cycles) fail_timeout("ready_o");
      if (random_drops) begin
        rnd_state = xorshift32(rnd_state);
        load = (rnd_state[1:0] != 2'b00);
      end else begin
        load = 1'b1;
      end
      @(posedge clk);
      #1;
      n++;
    end
    load = 1'b0;
  endtask

  task automatic check_contents();
    for (int r = 0; r < FI; r++) begin
      for (int b = 0; b < FO; b++) begin
        bank_rd_addr[b] = IDX_W'(r);
      end
      @(posedge clk);
      #1;
      for (int b = 0; b < FO; b++) begin
        check_value($sformatf("bank_rd_data_o[%0d] row %0d", b, r),
                    32'(bank_rd_data[b]), 32'(ref_word(S_W1, r * FO + b)));
      end
    end
    for (int i = 0; i < 2 * FO; i++) begin
      check_value($sformatf("attn1_o[%0d]", i), 32'(attn1[i]), 32'(ref_word(S_A1, i)));
    end
    for (int c = 0; c < FF; c++) begin
      for (int r = 0; r < FO; r++) begin
        check_value($sformatf("w2_o[%0d][%0d]", c, r), 32'(w2[c][r]),
                    32'(ref_word(S_W2, r * FF + c)));
      end
    end
    for (int i = 0; i < 2 * FF; i++) begin
      check_value($sformatf("attn2_o[%0d]", i), 32'(attn2[i]), 32'(ref_word(S_A2, i)));
    end
  endtask

  // ============================================================
  // Stream monitor
  // ============================================================
  // Address steps by one per load cycle and ready follows the end by two edges
  always @(negedge clk) begin
    if (!rst_n) begin
      prev_vld = 1'b0;
      end_cnt  = 0;
      wr_cnt   = 0;
    end else begin
      // Words presented to the destinations since reset
      if (DUT.wr.vld === 1'b1) wr_cnt++;
      if (prev_vld) begin
        exp_addr = prev_addr;
        if (prev_load && prev_addr < TOTAL) exp_addr = prev_addr + 1;
        check_value("wmem_addr_o", 32'(wmem_addr), 32'(exp_addr));
      end
      if (int'(wmem_addr) == TOTAL) end_cnt++;
      check_value("ready_o", 32'(ready), 32'(end_cnt >= 3));
      prev_addr = int'(wmem_addr);
      prev_load = load;
      prev_vld  = 1'b1;
    end
  end

  // ============================================================
  // Stimulus
  // ============================================================
  initial begin
    rst_n        = 1'b0;
    load         = 1'b0;
    bank_rd_addr = '0;
    rnd_state    = SEED;
    prev_vld     = 1'b0;
    end_cnt      = 0;
    wr_cnt       = 0;

    apply_reset();
    check_cleared();
    run_load(1'b0, 200);
    check_contents();
    check_value("wr.vld count", 32'(wr_cnt), 32'(TOTAL));

    // Second pass with pauses in the request
    apply_reset();
    check_cleared();
    run_load(1'b1, 600);
    check_contents();
    // Banks keep old data over reset, so count every placed word
    check_value("wr.vld count", 32'(wr_cnt), 32'(TOTAL));

    $display("** PASS **");
    $finish;
  end

endmodule

// File: compile.f
+incdir+.
wl_pkg.sv
weight_stream_seq.sv
weight_bank_array.sv
attn_vector_reg.sv
conv2_weight_reg.sv
weight_loader_top.sv
tb_weight_rom.sv
tb_weight_loader.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_weight_loader
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= ** PASS **

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
